// File: ctrl_assertions.sv
`timescale 1ns/1ps

module ctrl_assertions (
  input logic               clk,
  input logic               rst_n,
  input logic               irq_ack_o,
  input logic               exc_ack_o,
  input logic               ctrl_busy_o,
  input logic               instr_req_o,
  input ctrl_pkg::pc_ctrl_t pc_ctrl_o
);

  // a taken interrupt always redirects the fetch pc
  irq_ack_redirects: assert property (
    @(posedge clk) disable iff (!rst_n) irq_ack_o |-> pc_ctrl_o.pc_set
  ) else $error("irq_ack_o high without pc_set");

  // idle controller (reset, sleep) never redirects
  idle_no_redirect: assert property (
    @(posedge clk) disable iff (!rst_n) !ctrl_busy_o |-> !pc_ctrl_o.pc_set
  ) else $error("pc_set high while ctrl_busy_o is low");

  // only interrupts are acknowledged
  ack_pair: assert property (
    @(posedge clk) disable iff (!rst_n) exc_ack_o == irq_ack_o
  ) else $error("exc_ack_o differs from irq_ack_o");

  // no fetch request means the controller is idle
  busy_needs_req: assert property (
    @(posedge clk) disable iff (!rst_n) !instr_req_o |-> !ctrl_busy_o
  ) else $error("ctrl_busy_o high while instr_req_o is low");

endmodule

bind ctrl_top ctrl_assertions u_ctrl_assertions (.*);

// File: ctrl_fsm.sv
`timescale 1ns/1ps

module ctrl_fsm #(
  parameter int unsigned IRQ_ID_W = 5
) (
  input  logic                    clk,
  input  logic                    rst_n,

  // core enable and pipeline status
  input  logic                    fetch_enable_i,
  input  logic                    instr_valid_i,
  input  logic                    id_ready_i,
  input  ctrl_pkg::decode_flags_t flags_i,

  // interrupt request and enable
  input  logic                    irq_req_i,
  input  logic [IRQ_ID_W-1:0]     irq_id_i,
  input  logic                    mie_i,

  output logic                    instr_req_o,
  output logic                    ctrl_busy_o,
  output logic                    first_fetch_o,
  output logic                    is_decoding_o,
  output logic                    deassert_we_o,
  output logic                    halt_if_o,
  output logic                    halt_id_o,
  output ctrl_pkg::pc_ctrl_t      pc_ctrl_o,
  output trap_pkg::exc_cause_t    exc_cause_o,
  output logic                    exc_ack_o,
  output logic                    exc_kill_o,
  output logic                    irq_ack_o,
  output logic [IRQ_ID_W-1:0]     irq_id_o,
  output trap_pkg::trap_req_t     trap_req_o,
  output logic                    perf_jump_o,
  output logic                    perf_tbranch_o
);

  ctrl_pkg::ctrl_state_e state_q, state_d;

  // interrupt causes built from the id, zero padded to the cause width
  trap_pkg::exc_cause_t irq_exc_cause;
  trap_pkg::exc_cause_t irq_csr_cause;
  logic                 irq_pending;
  logic                 any_flush;

  always_comb begin
    irq_exc_cause                 = '0;
    irq_exc_cause[IRQ_ID_W-1:0]   = irq_id_i;
    irq_csr_cause                 = irq_exc_cause;
    // msb of mcause flags an interrupt
    irq_csr_cause[$bits(trap_pkg::exc_cause_t)-1] = 1'b1;
  end

  // interrupt can be taken only while mie is set
  assign irq_pending = irq_req_i & mie_i;

  // any flag that needs the pipeline emptied first
  assign any_flush = flags_i.mret | flags_i.ecall | flags_i.pipe_flush |
                     flags_i.illegal | flags_i.csr_status;

  ////////////////////
  // state logic
  ////////////////////

  always_comb begin
    // defaults, busy and fetching
    state_d              = state_q;
    instr_req_o          = 1'b1;
    ctrl_busy_o          = 1'b1;
    first_fetch_o        = 1'b0;
    is_decoding_o        = 1'b0;
    halt_if_o            = 1'b0;
    halt_id_o            = 1'b0;
    pc_ctrl_o.pc_set     = 1'b0;
    pc_ctrl_o.pc_mux     = ctrl_pkg::PC_BOOT;
    pc_ctrl_o.exc_pc_mux = ctrl_pkg::EXC_PC_IRQ;
    exc_cause_o          = '0;
    exc_ack_o            = 1'b0;
    exc_kill_o           = 1'b0;
    irq_ack_o            = 1'b0;
    irq_id_o             = irq_id_i;
    trap_req_o           = '0;
    perf_jump_o          = 1'b0;
    perf_tbranch_o       = 1'b0;

    unique case (state_q)
      // idle after reset until the core is enabled
      ctrl_pkg::RESET: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = ctrl_pkg::BOOT_SET;
        end
      end

      // load the boot address into the fetch pc
      ctrl_pkg::BOOT_SET: begin
        pc_ctrl_o.pc_set = 1'b1;
        pc_ctrl_o.pc_mux = ctrl_pkg::PC_BOOT;
        state_d          = ctrl_pkg::FIRST_FETCH;
      end

      // one cycle to drain before sleeping
      ctrl_pkg::WAIT_SLEEP: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        state_d     = ctrl_pkg::SLEEP;
      end

      // wake on enable or on any interrupt request, masked or not
      ctrl_pkg::SLEEP: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || irq_req_i) begin
          state_d = ctrl_pkg::FIRST_FETCH;
        end
      end

      // wait for the first instruction to reach decode
      ctrl_pkg::FIRST_FETCH: begin
        first_fetch_o = 1'b1;
        if (id_ready_i) begin
          state_d = ctrl_pkg::DECODE;
        end
        // pipeline is empty here, interrupt overrides
        if (irq_pending) begin
          state_d   = ctrl_pkg::IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end
      end

      ctrl_pkg::DECODE: begin
        if (instr_valid_i) begin
          is_decoding_o = 1'b1;
          // branch beats jump beats flush beats interrupt
          if (flags_i.branch_set) begin
            pc_ctrl_o.pc_set = 1'b1;
            pc_ctrl_o.pc_mux = ctrl_pkg::PC_JUMP;
            perf_tbranch_o   = 1'b1;
          end else if (flags_i.jump_set) begin
            pc_ctrl_o.pc_set = 1'b1;
            pc_ctrl_o.pc_mux = ctrl_pkg::PC_JUMP;
            perf_jump_o      = 1'b1;
          end else if (any_flush) begin
            state_d   = ctrl_pkg::FLUSH;
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
          end else if (irq_pending & ~flags_i.multicycle & ~flags_i.branch_in_id) begin
            state_d   = ctrl_pkg::IRQ_TAKEN;
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
          end else begin
            // request seen but masked, kill a pending exception
            exc_kill_o = irq_req_i & ~flags_i.multicycle & ~flags_i.branch_in_id;
          end
        end else if (irq_pending) begin
          // bubble in decode, nothing to protect
          state_d   = ctrl_pkg::IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end
      end

      // redirect to the handler and save the cause
      ctrl_pkg::IRQ_TAKEN: begin
        pc_ctrl_o.pc_set       = 1'b1;
        pc_ctrl_o.pc_mux       = ctrl_pkg::PC_EXCEPTION;
        pc_ctrl_o.exc_pc_mux   = ctrl_pkg::EXC_PC_IRQ;
        exc_cause_o            = irq_exc_cause;
        trap_req_o.save_cause  = 1'b1;
        trap_req_o.save_if     = 1'b1;
        trap_req_o.cause       = irq_csr_cause;
        irq_ack_o              = 1'b1;
        exc_ack_o              = 1'b1;
        state_d                = ctrl_pkg::DECODE;
      end

      // pipeline is empty, act on the held instruction
      ctrl_pkg::FLUSH: begin
        halt_if_o = ~fetch_enable_i;
        halt_id_o = 1'b1;
        if (flags_i.ecall) begin
          pc_ctrl_o.pc_set      = 1'b1;
          pc_ctrl_o.pc_mux      = ctrl_pkg::PC_EXCEPTION;
          pc_ctrl_o.exc_pc_mux  = ctrl_pkg::EXC_PC_ECALL;
          exc_cause_o           = trap_pkg::EXC_CAUSE_ECALL_MMODE;
          trap_req_o.save_cause = 1'b1;
          trap_req_o.save_id    = 1'b1;
          trap_req_o.cause      = trap_pkg::EXC_CAUSE_ECALL_MMODE;
        end else if (flags_i.illegal) begin
          pc_ctrl_o.pc_set      = 1'b1;
          pc_ctrl_o.pc_mux      = ctrl_pkg::PC_EXCEPTION;
          pc_ctrl_o.exc_pc_mux  = ctrl_pkg::EXC_PC_ILLINSN;
          exc_cause_o           = trap_pkg::EXC_CAUSE_ILLEGAL_INSN;
          trap_req_o.save_cause = 1'b1;
          trap_req_o.save_id    = 1'b1;
          trap_req_o.cause      = trap_pkg::EXC_CAUSE_ILLEGAL_INSN;
        end else if (flags_i.mret) begin
          pc_ctrl_o.pc_set        = 1'b1;
          pc_ctrl_o.pc_mux        = ctrl_pkg::PC_ERET;
          trap_req_o.restore_mret = 1'b1;
        end
        // csr_status and pipe_flush only empty the pipeline

        if (fetch_enable_i) begin
          state_d = ctrl_pkg::DECODE;
        end else if (flags_i.mret | flags_i.pipe_flush) begin
          state_d = ctrl_pkg::WAIT_SLEEP;
        end else begin
          state_d = ctrl_pkg::DECODE;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = ctrl_pkg::RESET;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ctrl_pkg::RESET;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////
  // stall logic
  ////////////////////

  // no register write unless a legal instruction is decoded
  assign deassert_we_o = ~is_decoding_o | flags_i.illegal;

endmodule

// File: ctrl_pkg.sv
package ctrl_pkg;

  // controller states, encoded in 4 bits
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_state_e;

  // program counter source seen by the fetch stage
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_mux_e;

  // exception vector select
  typedef enum logic [1:0] {
    EXC_PC_ILLINSN = 2'b00,
    EXC_PC_ECALL   = 2'b01,
    EXC_PC_IRQ     = 2'b11
  } exc_pc_mux_e;

  // per-instruction flags from the decoder
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic pipe_flush;
    logic csr_status;
    logic branch_set;
    logic jump_set;
    logic branch_in_id;
    logic multicycle;
  } decode_flags_t;

  // redirect request towards the fetch stage
  typedef struct packed {
    logic        pc_set;
    pc_mux_e     pc_mux;
    exc_pc_mux_e exc_pc_mux;
  } pc_ctrl_t;

endpackage

// File: ctrl_top.sv
`timescale 1ns/1ps

module ctrl_top #(
  parameter int unsigned IRQ_ID_W = $bits(trap_pkg::irq_id_t)
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    fetch_enable_i,
  input  logic                    instr_valid_i,
  input  logic                    id_ready_i,
  input  ctrl_pkg::decode_flags_t flags_i,
  input  logic                    irq_req_i,
  input  trap_pkg::irq_id_t       irq_id_i,
  input  logic                    mie_set_i,
  input  logic                    mie_clr_i,

  output logic                    instr_req_o,
  output logic                    ctrl_busy_o,
  output logic                    first_fetch_o,
  output logic                    is_decoding_o,
  output logic                    deassert_we_o,
  output logic                    halt_if_o,
  output logic                    halt_id_o,
  output ctrl_pkg::pc_ctrl_t      pc_ctrl_o,
  output trap_pkg::exc_cause_t    exc_cause_o,
  output logic                    exc_ack_o,
  output logic                    exc_kill_o,
  output logic                    irq_ack_o,
  output trap_pkg::irq_id_t       irq_id_o,
  output trap_pkg::trap_req_t     csr_save_o,
  output logic                    perf_jump_o,
  output logic                    perf_tbranch_o,
  output logic                    mie_o,
  output trap_pkg::exc_cause_t    mcause_o
);

  // trap strobes from the FSM, enable level back from the registers
  trap_pkg::trap_req_t trap_req;
  logic                mie;

  ctrl_fsm #(
    .IRQ_ID_W (IRQ_ID_W)
  ) u_ctrl_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .instr_valid_i  (instr_valid_i),
    .id_ready_i     (id_ready_i),
    .flags_i        (flags_i),
    .irq_req_i      (irq_req_i),
    .irq_id_i       (irq_id_i),
    .mie_i          (mie),
    .instr_req_o    (instr_req_o),
    .ctrl_busy_o    (ctrl_busy_o),
    .first_fetch_o  (first_fetch_o),
    .is_decoding_o  (is_decoding_o),
    .deassert_we_o  (deassert_we_o),
    .halt_if_o      (halt_if_o),
    .halt_id_o      (halt_id_o),
    .pc_ctrl_o      (pc_ctrl_o),
    .exc_cause_o    (exc_cause_o),
    .exc_ack_o      (exc_ack_o),
    .exc_kill_o     (exc_kill_o),
    .irq_ack_o      (irq_ack_o),
    .irq_id_o       (irq_id_o),
    .trap_req_o     (trap_req),
    .perf_jump_o    (perf_jump_o),
    .perf_tbranch_o (perf_tbranch_o)
  );

  trap_csr #(
    .IRQ_ID_W (IRQ_ID_W)
  ) u_trap_csr (
    .clk        (clk),
    .rst_n      (rst_n),
    .trap_req_i (trap_req),
    .mie_set_i  (mie_set_i),
    .mie_clr_i  (mie_clr_i),
    .mie_o      (mie),
    .mcause_o   (mcause_o)
  );

  assign csr_save_o = trap_req;
  assign mie_o      = mie;

endmodule

// File: project.f
ctrl_pkg.sv
trap_pkg.sv
ctrl_fsm.sv
trap_csr.sv
ctrl_top.sv
ctrl_assertions.sv
tb_checker.sv
tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the controller testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_top -f project.f \
    -o tb_sim > build.log 2>&1; then
  echo "build failed, see build.log"
  exit 1
fi

if ! ./obj_dir/tb_sim > sim.log 2>&1; then
  echo "simulation ended with an error, see sim.log"
  exit 1
fi

if grep -qx '\*\* PASS \*\*' sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// File: tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
  input logic clk,
  input logic rst_n
);

  // expected outputs of one cycle plus the state that follows
  typedef struct packed {
    logic                  instr_req;
    logic                  ctrl_busy;
    logic                  first_fetch;
    logic                  is_decoding;
    logic                  deassert_we;
    logic                  halt_if;
    logic                  halt_id;
    ctrl_pkg::pc_ctrl_t    pc_ctrl;
    trap_pkg::exc_cause_t  exc_cause;
    logic                  irq_ack;
    logic                  exc_ack;
    logic                  exc_kill;
    logic                  perf_jump;
    logic                  perf_tbranch;
    trap_pkg::trap_req_t   trap;
    ctrl_pkg::ctrl_state_e next;
  } exp_t;

  int checks     = 0;
  int errors     = 0;
  int tests      = 0;
  int test_base  = 0;

  // model of the controller and of the trap registers
  ctrl_pkg::ctrl_state_e model_state = ctrl_pkg::RESET;
  logic                  model_mie    = 1'b0;
  logic                  model_mpie   = 1'b0;
  trap_pkg::exc_cause_t  model_mcause = '0;
  exp_t                  e;

  ////////////////////
  // reference model
  ////////////////////

  function automatic exp_t ref_step(
    input ctrl_pkg::ctrl_state_e   st,
    input ctrl_pkg::decode_flags_t f,
    input logic                    fe,
    input logic                    valid,
    input logic                    ready,
    input logic                    irq,
    input trap_pkg::irq_id_t       id,
    input logic                    mie
  );
    exp_t r;
    logic pend;
    logic flush;
    r      = '0;
    r.next = st;
    pend   = irq & mie;
    flush  = f.illegal | f.ecall | f.mret | f.pipe_flush | f.csr_status;
    // idle in reset and while asleep
    r.instr_req = (st != ctrl_pkg::RESET) && (st != ctrl_pkg::WAIT_SLEEP) &&
                  (st != ctrl_pkg::SLEEP);
    r.ctrl_busy = r.instr_req;
    r.is_decoding = (st == ctrl_pkg::DECODE) && valid;
    r.deassert_we = !r.is_decoding || f.illegal;
    case (st)
      ctrl_pkg::RESET: begin
        if (fe) r.next = ctrl_pkg::BOOT_SET;
      end
      ctrl_pkg::BOOT_SET: begin
        r.pc_ctrl.pc_set = 1'b1;
        r.pc_ctrl.pc_mux = ctrl_pkg::PC_BOOT;
        r.next           = ctrl_pkg::FIRST_FETCH;
      end
      ctrl_pkg::WAIT_SLEEP: begin
        r.halt_if = 1'b1;
        r.halt_id = 1'b1;
        r.next    = ctrl_pkg::SLEEP;
      end
      ctrl_pkg::SLEEP: begin
        r.halt_if = 1'b1;
        r.halt_id = 1'b1;
        if (fe || irq) r.next = ctrl_pkg::FIRST_FETCH;
      end
      ctrl_pkg::FIRST_FETCH: begin
        r.first_fetch = 1'b1;
        if (pend) begin
          r.next    = ctrl_pkg::IRQ_TAKEN;
          r.halt_if = 1'b1;
          r.halt_id = 1'b1;
        end else if (ready) begin
          r.next = ctrl_pkg::DECODE;
        end
      end
      ctrl_pkg::DECODE: begin
        if (valid && (f.branch_set || f.jump_set)) begin
          // redirect in the same cycle with the branch counted first
          r.pc_ctrl.pc_set = 1'b1;
          r.pc_ctrl.pc_mux = ctrl_pkg::PC_JUMP;
          r.perf_tbranch   = f.branch_set;
          r.perf_jump      = !f.branch_set;
        end else if (valid && flush) begin
          r.next    = ctrl_pkg::FLUSH;
          r.halt_if = 1'b1;
          r.halt_id = 1'b1;
        end else if (pend && !(valid && (f.multicycle || f.branch_in_id))) begin
          r.next    = ctrl_pkg::IRQ_TAKEN;
          r.halt_if = 1'b1;
          r.halt_id = 1'b1;
        end else if (valid) begin
          r.exc_kill = irq & !f.multicycle & !f.branch_in_id;
        end
      end
      ctrl_pkg::IRQ_TAKEN: begin
        r.pc_ctrl.pc_set     = 1'b1;
        r.pc_ctrl.pc_mux     = ctrl_pkg::PC_EXCEPTION;
        r.pc_ctrl.exc_pc_mux = ctrl_pkg::EXC_PC_IRQ;
        r.exc_cause          = trap_pkg::exc_cause_t'(id);
        r.irq_ack            = 1'b1;
        r.exc_ack            = 1'b1;
        r.trap.save_cause    = 1'b1;
        r.trap.save_if       = 1'b1;
        // interrupt cause carries the msb
        r.trap.cause         = trap_pkg::exc_cause_t'(id);
        r.trap.cause[5]      = 1'b1;
        r.next               = ctrl_pkg::DECODE;
      end
      ctrl_pkg::FLUSH: begin
        // fetch stays halted only while the core is disabled
        r.halt_if = !fe;
        r.halt_id = 1'b1;
        if (f.ecall || f.illegal) begin
          r.pc_ctrl.pc_set     = 1'b1;
          r.pc_ctrl.pc_mux     = ctrl_pkg::PC_EXCEPTION;
          r.pc_ctrl.exc_pc_mux = f.ecall ? ctrl_pkg::EXC_PC_ECALL : ctrl_pkg::EXC_PC_ILLINSN;
          r.exc_cause          = f.ecall ? trap_pkg::EXC_CAUSE_ECALL_MMODE :
                                           trap_pkg::EXC_CAUSE_ILLEGAL_INSN;
          r.trap.save_cause    = 1'b1;
          r.trap.save_id       = 1'b1;
          r.trap.cause         = r.exc_cause;
        end else if (f.mret) begin
          r.pc_ctrl.pc_set    = 1'b1;
          r.pc_ctrl.pc_mux    = ctrl_pkg::PC_ERET;
          r.trap.restore_mret = 1'b1;
        end
        // sleep only after mret or fence-like flush with fetch disabled
        r.next = (!fe && (f.mret || f.pipe_flush)) ? ctrl_pkg::WAIT_SLEEP : ctrl_pkg::DECODE;
      end
      default: begin
        r.next = ctrl_pkg::RESET;
      end
    endcase
    return r;
  endfunction

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = errors - test_base;
    tests++;
    if (errs == 0) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errs);
    end
    test_base = errors;
  endtask

  task automatic report_counts();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
  endtask

  ////////////////////
  // compare
  ////////////////////

  // falling edge sees the inputs settled after the rising edge update
  always @(negedge clk) begin
    e = ref_step(model_state, tb_top.dut.flags_i, tb_top.dut.fetch_enable_i,
                 tb_top.dut.instr_valid_i, tb_top.dut.id_ready_i, tb_top.dut.irq_req_i,
                 tb_top.dut.irq_id_i, model_mie);
    check_value("instr_req_o", 16'(tb_top.dut.instr_req_o), 16'(e.instr_req));
    check_value("ctrl_busy_o", 16'(tb_top.dut.ctrl_busy_o), 16'(e.ctrl_busy));
    check_value("first_fetch_o", 16'(tb_top.dut.first_fetch_o), 16'(e.first_fetch));
    check_value("is_decoding_o", 16'(tb_top.dut.is_decoding_o), 16'(e.is_decoding));
    check_value("deassert_we_o", 16'(tb_top.dut.deassert_we_o), 16'(e.deassert_we));
    check_value("halt_if_o", 16'(tb_top.dut.halt_if_o), 16'(e.halt_if));
    check_value("halt_id_o", 16'(tb_top.dut.halt_id_o), 16'(e.halt_id));
    check_value("pc_set", 16'(tb_top.dut.pc_ctrl_o.pc_set), 16'(e.pc_ctrl.pc_set));
    // mux selects only matter while a redirect is requested
    if (e.pc_ctrl.pc_set) begin
      check_value("pc_mux", 16'(tb_top.dut.pc_ctrl_o.pc_mux), 16'(e.pc_ctrl.pc_mux));
    end
    if (e.pc_ctrl.pc_set && e.pc_ctrl.pc_mux == ctrl_pkg::PC_EXCEPTION) begin
      check_value("exc_pc_mux", 16'(tb_top.dut.pc_ctrl_o.exc_pc_mux),
                  16'(e.pc_ctrl.exc_pc_mux));
    end
    check_value("exc_cause_o", 16'(tb_top.dut.exc_cause_o), 16'(e.exc_cause));
    check_value("irq_ack_o", 16'(tb_top.dut.irq_ack_o), 16'(e.irq_ack));
    check_value("exc_ack_o", 16'(tb_top.dut.exc_ack_o), 16'(e.exc_ack));
    check_value("exc_kill_o", 16'(tb_top.dut.exc_kill_o), 16'(e.exc_kill));
    if (e.irq_ack) begin
      check_value("irq_id_o", 16'(tb_top.dut.irq_id_o), 16'(tb_top.dut.irq_id_i));
    end
    check_value("csr_save_o", 16'(tb_top.dut.csr_save_o), 16'(e.trap));
    check_value("perf_jump_o", 16'(tb_top.dut.perf_jump_o), 16'(e.perf_jump));
    check_value("perf_tbranch_o", 16'(tb_top.dut.perf_tbranch_o), 16'(e.perf_tbranch));
    check_value("mie_o", 16'(tb_top.dut.mie_o), 16'(model_mie));
    check_value("mcause_o", 16'(tb_top.dut.mcause_o), 16'(model_mcause));

    if (!rst_n) begin
      model_state  = ctrl_pkg::RESET;
      model_mie    = 1'b0;
      model_mpie   = 1'b0;
      model_mcause = '0;
    end else begin
      model_state = e.next;
      // trap strobes beat the software set and clear
      if (e.trap.save_cause) begin
        model_mpie   = model_mie;
        model_mie    = 1'b0;
        model_mcause = e.trap.cause;
      end else if (e.trap.restore_mret) begin
        model_mie  = model_mpie;
        model_mpie = 1'b1;
      end else if (tb_top.dut.mie_clr_i) begin
        model_mie = 1'b0;
      end else if (tb_top.dut.mie_set_i) begin
        model_mie = 1'b1;
      end
    end
  end

endmodule

// File: tb_top.sv
`timescale 1ns/1ps

module tb_top;

  localparam int RESET_CYCLES = 16;
  localparam int NUM_TESTS    = 5;
  // each test stays well inside 40 cycles
  localparam int CYCLE_LIMIT  = 40 * NUM_TESTS + RESET_CYCLES;

  logic                    clk;
  logic                    rst_n;
  logic                    fetch_enable;
  logic                    instr_valid;
  logic                    id_ready;
  ctrl_pkg::decode_flags_t flags;
  logic                    irq_req;
  trap_pkg::irq_id_t       irq_id;
  logic                    mie_set;
  logic                    mie_clr;

  integer      seed = 32'he89e;
  logic [31:0] rnd;
  int          cycle_count = 0;

  ctrl_top #(
    .IRQ_ID_W ($bits(trap_pkg::irq_id_t))
  ) dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable),
    .instr_valid_i  (instr_valid),
    .id_ready_i     (id_ready),
    .flags_i        (flags),
    .irq_req_i      (irq_req),
    .irq_id_i       (irq_id),
    .mie_set_i      (mie_set),
    .mie_clr_i      (mie_clr),
    .instr_req_o    (),
    .ctrl_busy_o    (),
    .first_fetch_o  (),
    .is_decoding_o  (),
    .deassert_we_o  (),
    .halt_if_o      (),
    .halt_id_o      (),
    .pc_ctrl_o      (),
    .exc_cause_o    (),
    .exc_ack_o      (),
    .exc_kill_o     (),
    .irq_ack_o      (),
    .irq_id_o       (),
    .csr_save_o     (),
    .perf_jump_o    (),
    .perf_tbranch_o (),
    .mie_o          (),
    .mcause_o       ()
  );

  tb_checker chk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("** FAIL **");
      $display("timeout: run stopped after %0d cycles", cycle_count);
      $finish;
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  // inputs change 1 ns after the edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_pc_set(input ctrl_pkg::pc_mux_e mux, input string what);
    bit seen;
    seen = 1'b0;
    for (int n = 0; n < 8 && !seen; n++) begin
      step();
      seen = dut.pc_ctrl_o.pc_set && (dut.pc_ctrl_o.pc_mux == mux);
    end
    if (!seen) chk.report_failure({what, " redirect did not appear within 8 cycles"});
  endtask

  task automatic wait_irq_ack(input string what);
    bit seen;
    seen = 1'b0;
    for (int n = 0; n < 8 && !seen; n++) begin
      step();
      seen = dut.irq_ack_o;
    end
    if (!seen) chk.report_failure({what, " was never acknowledged"});
  endtask

  task automatic wait_busy(input logic level, input string what);
    bit seen;
    seen = 1'b0;
    for (int n = 0; n < 8 && !seen; n++) begin
      step();
      seen = (dut.ctrl_busy_o == level);
    end
    if (!seen) chk.report_failure({what, " did not change ctrl_busy_o in time"});
  endtask

  // decoded ecall or illegal goes through FLUSH, flags held for that cycle
  task automatic run_exception(input logic is_ecall, input string what);
    flags         = '0;
    flags.ecall   = is_ecall;
    flags.illegal = ~is_ecall;
    wait_pc_set(ctrl_pkg::PC_EXCEPTION, what);
    step();
    flags = '0;
    step();
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    instr_valid  = 1'b0;
    id_ready     = 1'b0;
    flags        = '0;
    irq_req      = 1'b0;
    irq_id       = '0;
    mie_set      = 1'b0;
    mie_clr      = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;

    // reset wait, boot pc, first fetch stalled on id_ready
    step();
    step();
    fetch_enable = 1'b1;
    wait_pc_set(ctrl_pkg::PC_BOOT, "boot");
    repeat (3) step();
    id_ready = 1'b1;
    step();
    chk.end_test("reset_boot");

    // random branch and jump flags in decode
    instr_valid = 1'b1;
    repeat (8) begin
      rnd                = $random(seed);
      flags              = '0;
      flags.branch_set   = rnd[0];
      flags.jump_set     = rnd[1];
      flags.branch_in_id = rnd[2];
      step();
    end
    flags = '0;
    step();
    chk.end_test("branch_jump");

    run_exception(1'b1, "ecall");
    run_exception(1'b0, "illegal instruction");
    // plain pipeline flush with fetch enabled returns to decode
    flags.pipe_flush = 1'b1;
    step();
    step();
    flags = '0;
    step();
    chk.end_test("exceptions");

    // set, then set with clear where clear wins, then set again
    mie_set = 1'b1;
    step();
    mie_clr = 1'b1;
    step();
    mie_clr = 1'b0;
    step();
    mie_set = 1'b0;
    rnd     = $random(seed);
    irq_id  = rnd[4:0];
    irq_req = 1'b1;
    wait_irq_ack("enabled interrupt");
    irq_req = 1'b0;
    step();
    // masked request, only exc_kill_o
    irq_req = 1'b1;
    repeat (4) step();
    irq_req = 1'b0;
    mie_set = 1'b1;
    step();
    mie_set          = 1'b0;
    flags.multicycle = 1'b1;
    rnd              = $random(seed);
    irq_id           = rnd[4:0];
    irq_req          = 1'b1;
    repeat (3) step();
    flags = '0;
    wait_irq_ack("interrupt after multicycle");
    irq_req = 1'b0;
    step();
    chk.end_test("interrupts");

    // mret with fetch disabled goes to sleep, interrupt wakes it
    fetch_enable = 1'b0;
    flags.mret   = 1'b1;
    wait_pc_set(ctrl_pkg::PC_ERET, "mret");
    step();
    flags       = '0;
    instr_valid = 1'b0;
    wait_busy(1'b0, "sleep entry");
    repeat (2) step();
    rnd     = $random(seed);
    irq_id  = rnd[4:0];
    irq_req = 1'b1;
    wait_busy(1'b1, "wake-up");
    wait_irq_ack("wake-up interrupt");
    irq_req      = 1'b0;
    fetch_enable = 1'b1;
    repeat (2) step();
    chk.end_test("mret_sleep");

    chk.report_counts();
    if (chk.errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: trap_csr.sv
`timescale 1ns/1ps

module trap_csr #(
  parameter int unsigned IRQ_ID_W = 5
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  trap_pkg::trap_req_t  trap_req_i,
  input  logic                 mie_set_i,
  input  logic                 mie_clr_i,
  output logic                 mie_o,
  output trap_pkg::exc_cause_t mcause_o
);

  localparam int unsigned CAUSE_W = $bits(trap_pkg::exc_cause_t);

  logic                 mie_q;
  logic                 mpie_q;
  trap_pkg::exc_cause_t mcause_q;
  trap_pkg::exc_cause_t cause_d;

  // interrupt causes keep only the implemented id bits
  always_comb begin
    cause_d = trap_req_i.cause;
    if (trap_req_i.cause[CAUSE_W-1]) begin
      cause_d                = '0;
      cause_d[CAUSE_W-1]     = 1'b1;
      cause_d[IRQ_ID_W-1:0]  = trap_req_i.cause[IRQ_ID_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mcause_q <= '0;
    end else if (trap_req_i.save_cause) begin
      // trap entry stacks the enable and masks further interrupts
      mpie_q   <= mie_q;
      mie_q    <= 1'b0;
      mcause_q <= cause_d;
    end else if (trap_req_i.restore_mret) begin
      // return pops the saved enable
      mie_q  <= mpie_q;
      mpie_q <= 1'b1;
    end else if (mie_clr_i) begin
      mie_q <= 1'b0;
    end else if (mie_set_i) begin
      mie_q <= 1'b1;
    end
  end

  assign mie_o    = mie_q;
  assign mcause_o = mcause_q;

endmodule

// File: trap_pkg.sv
package trap_pkg;

  // interrupt line number
  typedef logic [4:0] irq_id_t;

  // exception cause code, msb marks an interrupt
  typedef logic [5:0] exc_cause_t;

  // synchronous exception causes
  localparam exc_cause_t EXC_CAUSE_ILLEGAL_INSN = 6'd2;
  localparam exc_cause_t EXC_CAUSE_ECALL_MMODE  = 6'd11;

  // strobes from the controller into the trap registers
  // save_if   pc of the fetch stage goes to mepc (interrupt)
  // save_id   pc of the decode stage goes to mepc (exception)
  typedef struct packed {
    logic       save_cause;
    logic       save_if;
    logic       save_id;
    logic       restore_mret;
    exc_cause_t cause;
  } trap_req_t;

endpackage
